// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_spmm
RTL_TOP   ?= spmm_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
JOBS      ?= 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q '>>> PASS' $(LOG); then echo "No result line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sp_pe.sv
// Sparse processing element, signed multiply-accumulate against one weight column
`timescale 1ns/1ps

module sp_pe import spmm_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     vld_i,
  input  logic                     first_i,
  input  logic                     clr_i,
  input  logic signed [DATA_W-1:0] val_i,
  input  logic signed [DATA_W-1:0] wgt_i,
  output logic signed [RES_W-1:0]  res_o
);

  logic signed [2*DATA_W-1:0] prod;
  logic signed [RES_W-1:0]    prod_ext;
  logic signed [RES_W-1:0]    acc_q;

  // ====================================================================
  // Multiply
  // ====================================================================
  assign prod     = val_i * wgt_i;
  assign prod_ext = {{(RES_W - 2*DATA_W){prod[2*DATA_W-1]}}, prod};

  // ====================================================================
  // Accumulate
  // ====================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= '0;
    end else if (clr_i) begin
      acc_q <= '0;
    end else if (vld_i) begin
      // First entry of a row overwrites the previous result
      if (first_i) begin
        acc_q <= prod_ext;
      end else begin
        acc_q <= acc_q + prod_ext;
      end
    end
  end

  // Result held until the next row starts
  assign res_o = acc_q;

endmodule

// File: spmm_ctrl.sv
// Row sequencing FSM with load gating and aligned element strobes
`timescale 1ns/1ps

module spmm_ctrl import spmm_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  // Host side
  input  logic                 start_i,
  input  logic [ROW_LEN_W-1:0] row_len_i,
  input  logic                 load_we_i,
  output logic                 store_we_o,
  // Counter side
  output logic                 cnt_clr_o,
  output logic                 cnt_en_o,
  input  logic                 cnt_last_i,
  input  logic                 cnt_first_i,
  // Processing elements
  output logic                 pe_vld_o,
  output logic                 pe_first_o,
  output logic                 pe_clr_o,
  // Status
  output logic                 busy_o,
  output logic                 done_o
);

  logic [STATE_W-1:0] state_q;
  logic [STATE_W-1:0] state_d;
  logic               start_ok;
  logic               pe_vld_q;
  logic               pe_first_q;
  logic               pe_clr_q;

  // Start only counts when idle
  assign start_ok = (state_q == ST_IDLE) && start_i;

  // ====================================================================
  // State machine
  // ====================================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (start_i) begin
          // Empty row skips streaming
          state_d = (row_len_i == '0) ? ST_DRAIN : ST_STREAM;
        end
      end
      ST_STREAM: begin
        if (cnt_last_i) begin
          state_d = ST_DRAIN;
        end
      end
      ST_DRAIN: state_d = ST_DONE;
      ST_DONE:  state_d = ST_IDLE;
      default:  state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ====================================================================
  // Element strobes, one cycle behind the issued index
  // ====================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pe_vld_q   <= 1'b0;
      pe_first_q <= 1'b0;
      pe_clr_q   <= 1'b0;
    end else begin
      pe_vld_q   <= (state_q == ST_STREAM);
      pe_first_q <= (state_q == ST_STREAM) && cnt_first_i;
      pe_clr_q   <= start_ok && (row_len_i == '0);
    end
  end

  assign pe_vld_o   = pe_vld_q;
  assign pe_first_o = pe_first_q;
  assign pe_clr_o   = pe_clr_q;

  // Counter control
  assign cnt_clr_o  = start_ok;
  assign cnt_en_o   = (state_q == ST_STREAM);

  // Loads dropped while a row is running
  assign store_we_o = load_we_i && (state_q == ST_IDLE);

  assign busy_o     = (state_q != ST_IDLE);
  assign done_o     = (state_q == ST_DONE);

endmodule

// File: spmm_nnz_counter.sv
// Shared non-zero entry index counter with first and last flags
`timescale 1ns/1ps

module spmm_nnz_counter import spmm_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 clr_i,
  input  logic                 en_i,
  input  logic [ROW_LEN_W-1:0] len_i,
  output logic [COL_IDX_W-1:0] idx_o,
  output logic                 first_o,
  output logic                 last_o
);

  logic [COL_IDX_W-1:0] idx_q;
  logic [ROW_LEN_W-1:0] len_q;

  // Row length held for the whole row
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idx_q <= '0;
      len_q <= '0;
    end else if (clr_i) begin
      idx_q <= '0;
      len_q <= len_i;
    end else if (en_i) begin
      idx_q <= idx_q + 1'b1;
    end
  end

  assign idx_o   = idx_q;
  assign first_o = (idx_q == '0);

  // Zero length never matches, the controller skips streaming then
  assign last_o  = ({1'b0, idx_q} == (len_q - 1'b1));

endmodule

// File: spmm_operand_store.sv
// Feature entry list and weight matrix registers with load port and entry read port
`timescale 1ns/1ps

module spmm_operand_store import spmm_pkg::*; (
  input  logic                                 clk,
  input  logic                                 rst_n,
  // Load port
  input  logic                                 we_i,
  input  logic                                 sel_i,
  input  logic [COL_IDX_W-1:0]                 addr_i,
  input  spmm_load_u                           data_i,
  // Read port
  input  logic [COL_IDX_W-1:0]                 rd_idx_i,
  output spmm_entry_t                          entry_o,
  output logic [NUM_FEAT_OUT-1:0][DATA_W-1:0]  wgt_o
);

  // ====================================================================
  // Storage
  // ====================================================================
  spmm_entry_t              feat_q [NUM_FEAT_IN];
  logic [NUM_FEAT_OUT-1:0][DATA_W-1:0] wgt_q [NUM_FEAT_IN];
  spmm_entry_t              entry_q;

  // ====================================================================
  // Load decode
  // ====================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_FEAT_IN; i++) begin
        feat_q[i] <= '0;
        wgt_q[i]  <= '0;
      end
    end else if (we_i) begin
      if (!sel_i) begin
        // Feature view, slot chosen by addr_i
        feat_q[addr_i].col <= data_i.feat.col;
        feat_q[addr_i].val <= data_i.feat.val;
      end else begin
        // Weight view carries its own row and column
        wgt_q[data_i.wgt.row][data_i.wgt.col] <= data_i.wgt.val;
      end
    end
  end

  // ====================================================================
  // Entry read
  // ====================================================================
  // Entry registered one cycle after the index is issued
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      entry_q <= '0;
    end else begin
      entry_q <= feat_q[rd_idx_i];
    end
  end

  assign entry_o = entry_q;

  // Whole weight row at the entry's column, one value per element
  always_comb begin
    for (int j = 0; j < NUM_FEAT_OUT; j++) begin
      wgt_o[j] = wgt_q[entry_q.col][j];
    end
  end

endmodule

// File: spmm_pkg.sv
// Widths, controller state codes, load word union, entry and result structs
package spmm_pkg;

  // ====================================================================
  // Operand and datapath widths
  // ====================================================================
  // Feature and weight values
  localparam int DATA_W       = 8;
  // 16 input features
  localparam int COL_IDX_W    = 4;
  localparam int NUM_FEAT_IN  = 16;
  // Weight columns, one processing element each
  localparam int NUM_FEAT_OUT = 4;
  localparam int W_COL_W      = 2;
  // Row length runs 0 to 16 so one extra bit
  localparam int ROW_LEN_W    = 5;
  // 16 products of 16 bits fit in 20 bits signed
  localparam int RES_W        = 20;
  localparam int LOAD_W       = 16;

  // Pad widths of the two load views
  localparam int FEAT_PAD_W   = LOAD_W - COL_IDX_W - DATA_W;
  localparam int WGT_PAD_W    = LOAD_W - COL_IDX_W - W_COL_W - DATA_W;

  // ====================================================================
  // Controller states
  // ====================================================================
  localparam int              STATE_W   = 2;
  localparam logic [STATE_W-1:0] ST_IDLE   = 2'd0;
  localparam logic [STATE_W-1:0] ST_STREAM = 2'd1;
  localparam logic [STATE_W-1:0] ST_DRAIN  = 2'd2;
  localparam logic [STATE_W-1:0] ST_DONE   = 2'd3;

  // ====================================================================
  // Load word, decoded as feature entry or as weight
  // ====================================================================
  // Feature entry view
  typedef struct packed {
    logic [FEAT_PAD_W-1:0] pad;
    logic [COL_IDX_W-1:0]  col;
    logic [DATA_W-1:0]     val;
  } spmm_feat_view_t;

  // Weight view, row is the input feature index
  typedef struct packed {
    logic [COL_IDX_W-1:0]  row;
    logic [W_COL_W-1:0]    col;
    logic [WGT_PAD_W-1:0]  pad;
    logic [DATA_W-1:0]     val;
  } spmm_wgt_view_t;

  typedef union packed {
    spmm_feat_view_t feat;
    spmm_wgt_view_t  wgt;
  } spmm_load_u;

  // ====================================================================
  // Datapath bundles
  // ====================================================================
  // One non-zero entry of the sparse row
  typedef struct packed {
    logic [COL_IDX_W-1:0] col;
    logic [DATA_W-1:0]    val;
  } spmm_entry_t;

  // Four dot products, column 0 in the low field
  typedef struct packed {
    logic signed [RES_W-1:0] res3;
    logic signed [RES_W-1:0] res2;
    logic signed [RES_W-1:0] res1;
    logic signed [RES_W-1:0] res0;
  } spmm_result_t;

endpackage

// File: spmm_top.sv
// Sparse-times-dense engine top: operand store, counter, controller, four elements
`timescale 1ns/1ps

module spmm_top import spmm_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  // Load port
  input  logic                 load_we_i,
  input  logic                 load_sel_i,
  input  logic [COL_IDX_W-1:0] load_addr_i,
  input  spmm_load_u           load_data_i,
  // Row start
  input  logic                 start_i,
  input  logic [ROW_LEN_W-1:0] row_len_i,
  // Status and results
  output logic                 busy_o,
  output logic                 done_o,
  output spmm_result_t         result_o
);

  logic                                 store_we;
  logic                                 cnt_clr;
  logic                                 cnt_en;
  logic [COL_IDX_W-1:0]                 cnt_idx;
  logic                                 cnt_first;
  logic                                 cnt_last;
  logic                                 pe_vld;
  logic                                 pe_first;
  logic                                 pe_clr;
  spmm_entry_t                          entry;
  logic [NUM_FEAT_OUT-1:0][DATA_W-1:0]  wgt;
  logic [NUM_FEAT_OUT-1:0][RES_W-1:0]   pe_res;

  // ====================================================================
  // Operands and sequencing
  // ====================================================================
  spmm_operand_store u_store (
    .clk      (clk),
    .rst_n    (rst_n),
    .we_i     (store_we),
    .sel_i    (load_sel_i),
    .addr_i   (load_addr_i),
    .data_i   (load_data_i),
    .rd_idx_i (cnt_idx),
    .entry_o  (entry),
    .wgt_o    (wgt)
  );

  spmm_nnz_counter u_cnt (
    .clk     (clk),
    .rst_n   (rst_n),
    .clr_i   (cnt_clr),
    .en_i    (cnt_en),
    .len_i   (row_len_i),
    .idx_o   (cnt_idx),
    .first_o (cnt_first),
    .last_o  (cnt_last)
  );

  spmm_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .row_len_i   (row_len_i),
    .load_we_i   (load_we_i),
    .store_we_o  (store_we),
    .cnt_clr_o   (cnt_clr),
    .cnt_en_o    (cnt_en),
    .cnt_last_i  (cnt_last),
    .cnt_first_i (cnt_first),
    .pe_vld_o    (pe_vld),
    .pe_first_o  (pe_first),
    .pe_clr_o    (pe_clr),
    .busy_o      (busy_o),
    .done_o      (done_o)
  );

  // ====================================================================
  // One element per weight column
  // ====================================================================
  for (genvar g = 0; g < NUM_FEAT_OUT; g++) begin : g_pe
    sp_pe u_pe (
      .clk     (clk),
      .rst_n   (rst_n),
      .vld_i   (pe_vld),
      .first_i (pe_first),
      .clr_i   (pe_clr),
      .val_i   (entry.val),
      .wgt_i   (wgt[g]),
      .res_o   (pe_res[g])
    );
  end

  // Element 0 lands in the low field
  assign result_o = spmm_result_t'(pe_res);

endmodule

// File: src.f
spmm_pkg.sv
spmm_operand_store.sv
spmm_nnz_counter.sv
spmm_ctrl.sv
sp_pe.sv
spmm_top.sv
tb_spmm.sv

// File: tb_spmm.sv
// Testbench with clock, reset, watchdog, reference model and directed tests for the engine
`timescale 1ns/1ps

module tb_spmm;
  import spmm_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int RST_CYCLES  = 16;
  localparam int NUM_ROWS    = 16;
  // Full operand reload plus the longest row and some slack
  localparam int ROW_CYCLES  = NUM_FEAT_IN * (NUM_FEAT_OUT + 1) + NUM_FEAT_IN + 8;
  localparam int WDOG_CYCLES = RST_CYCLES + NUM_ROWS * ROW_CYCLES + 200;

  logic                 clk;
  logic                 rst_n;
  logic                 load_we;
  logic                 load_sel;
  logic [COL_IDX_W-1:0] load_addr;
  spmm_load_u           load_data;
  logic                 start;
  logic [ROW_LEN_W-1:0] row_len;
  logic                 busy_o;
  logic                 done_o;
  spmm_result_t         result_o;

  // ====================================================================
  // Reference copy of the operands
  // ====================================================================
  logic [COL_IDX_W-1:0]     m_col [NUM_FEAT_IN];
  logic signed [DATA_W-1:0] m_val [NUM_FEAT_IN];
  logic signed [DATA_W-1:0] m_wgt [NUM_FEAT_IN][NUM_FEAT_OUT];
  int                       last_res [NUM_FEAT_OUT];
  int                       errors;
  int                       checks;

  spmm_top dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_we_i   (load_we),
    .load_sel_i  (load_sel),
    .load_addr_i (load_addr),
    .load_data_i (load_data),
    .start_i     (start),
    .row_len_i   (row_len),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .result_o    (result_o)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic int rand_byte();
    return int'($urandom_range(0, 255)) - 128;
  endfunction

  // Sum over the row of value times the weight at the entry's column
  function automatic int expected(int len, int j);
    int sum;
    sum = 0;
    for (int i = 0; i < len; i++) begin
      sum += int'(m_val[i]) * int'(m_wgt[m_col[i]][j]);
    end
    return sum;
  endfunction

  function automatic int field_of(spmm_result_t r, int j);
    case (j)
      0:       return int'(r.res0);
      1:       return int'(r.res1);
      2:       return int'(r.res2);
      default: return int'(r.res3);
    endcase
  endfunction

  task automatic check_val(string name, int exp, int act);
    checks++;
    if (exp != act) begin
      errors++;
      $display("Fail %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic load_entry(int slot, int col, int val);
    spmm_load_u w;
    w          = '0;
    w.feat.col = COL_IDX_W'(col);
    w.feat.val = DATA_W'(val);
    @(posedge clk);
    load_we   <= 1'b1;
    load_sel  <= 1'b0;
    load_addr <= COL_IDX_W'(slot);
    load_data <= w;
    m_col[slot] = COL_IDX_W'(col);
    m_val[slot] = DATA_W'(val);
  endtask

  task automatic load_weight(int row, int col, int val);
    spmm_load_u w;
    w         = '0;
    w.wgt.row = COL_IDX_W'(row);
    w.wgt.col = W_COL_W'(col);
    w.wgt.val = DATA_W'(val);
    @(posedge clk);
    load_we   <= 1'b1;
    load_sel  <= 1'b1;
    load_addr <= '0;
    load_data <= w;
    m_wgt[row][col] = DATA_W'(val);
  endtask

  // ====================================================================
  // Start one row, wait for done, check latency, busy and results
  // ====================================================================
  task automatic run_row(string name, int len, bit inject);
    int cyc;
    bit seen;
    @(posedge clk);
    load_we <= 1'b0;
    start   <= 1'b1;
    row_len <= ROW_LEN_W'(len);
    @(posedge clk);
    start <= 1'b0;
    cyc  = 0;
    seen = 1'b0;
    while (!seen && cyc < len + 8) begin
      @(negedge clk);
      cyc++;
      if (done_o) begin
        seen = 1'b1;
      end else if (!busy_o) begin
        errors++;
        $display("%s: busy_o low in cycle %0d before done", name, cyc);
      end
      if (!seen) begin
        @(posedge clk);
        if (inject && cyc == 1) begin
          // Stray start and write to the last entry slot while busy
          start     <= 1'b1;
          row_len   <= ROW_LEN_W'(1);
          load_we   <= 1'b1;
          load_sel  <= 1'b0;
          load_addr <= COL_IDX_W'(len - 1);
          load_data <= '1;
        end else begin
          start   <= 1'b0;
          load_we <= 1'b0;
        end
      end
    end
    if (!seen) begin
      errors++;
      $display("%s: done_o never arrived", name);
    end else begin
      check_val({name, " latency"}, len + 2, cyc);
      check_val({name, " busy at done"}, 1, int'(busy_o));
      for (int j = 0; j < NUM_FEAT_OUT; j++) begin
        last_res[j] = field_of(result_o, j);
        check_val($sformatf("%s res%0d", name, j), expected(len, j), last_res[j]);
      end
      // Done is a single cycle pulse
      @(negedge clk);
      check_val({name, " done after pulse"}, 0, int'(done_o));
      check_val({name, " busy after pulse"}, 0, int'(busy_o));
    end
  endtask

  // ====================================================================
  // Directed tests
  // ====================================================================
  task automatic test_reset();
    @(negedge clk);
    check_val("reset busy", 0, int'(busy_o));
    check_val("reset done", 0, int'(done_o));
    for (int j = 0; j < NUM_FEAT_OUT; j++) begin
      check_val($sformatf("reset res%0d", j), 0, field_of(result_o, j));
    end
    run_row("zero_row", 0, 1'b0);
  endtask

  task automatic test_single();
    int col;
    col = int'($urandom_range(0, NUM_FEAT_IN - 1));
    load_entry(0, col, rand_byte());
    for (int j = 0; j < NUM_FEAT_OUT; j++) begin
      load_weight(col, j, rand_byte());
    end
    run_row("single", 1, 1'b0);
  endtask

  task automatic test_full();
    for (int i = 0; i < NUM_FEAT_IN; i++) begin
      load_entry(i, int'($urandom_range(0, NUM_FEAT_IN - 1)), rand_byte());
    end
    for (int r = 0; r < NUM_FEAT_IN; r++) begin
      for (int c = 0; c < NUM_FEAT_OUT; c++) begin
        load_weight(r, c, rand_byte());
      end
    end
    run_row("full_row", NUM_FEAT_IN, 1'b0);
  endtask

  task automatic test_extremes();
    for (int r = 0; r < NUM_FEAT_IN; r++) begin
      for (int c = 0; c < NUM_FEAT_OUT; c++) begin
        load_weight(r, c, (c % 2 == 0) ? -128 : 127);
      end
    end
    for (int i = 0; i < NUM_FEAT_IN; i++) begin
      load_entry(i, int'($urandom_range(0, NUM_FEAT_IN - 1)), -128);
    end
    run_row("extreme_neg", NUM_FEAT_IN, 1'b0);
    for (int i = 0; i < NUM_FEAT_IN; i++) begin
      load_entry(i, int'(m_col[i]), 127);
    end
    run_row("extreme_pos", NUM_FEAT_IN, 1'b0);
    // Empty row clears the held non-zero results
    run_row("extreme_zero", 0, 1'b0);
  endtask

  task automatic test_back_to_back();
    int len;
    for (int n = 0; n < 6; n++) begin
      len = int'($urandom_range(0, NUM_FEAT_IN));
      // Narrow column range so indexes repeat
      for (int i = 0; i < len; i++) begin
        load_entry(i, int'($urandom_range(0, 5)), rand_byte());
      end
      for (int k = 0; k < 4; k++) begin
        load_weight(int'($urandom_range(0, 5)), int'($urandom_range(0, 3)), rand_byte());
      end
      run_row($sformatf("sparse_row%0d", n), len, len > 2);
    end
  endtask

  task automatic test_weight_view();
    int prev [NUM_FEAT_OUT];
    int c;
    for (int i = 0; i < 8; i++) begin
      load_entry(i, int'($urandom_range(0, NUM_FEAT_IN - 1)), rand_byte());
    end
    run_row("wview_a", 8, 1'b0);
    prev = last_res;
    c = int'($urandom_range(0, NUM_FEAT_OUT - 1));
    for (int r = 0; r < NUM_FEAT_IN; r++) begin
      load_weight(r, c, rand_byte());
    end
    run_row("wview_b", 8, 1'b0);
    for (int j = 0; j < NUM_FEAT_OUT; j++) begin
      if (j != c) begin
        check_val($sformatf("wview_other res%0d", j), prev[j], last_res[j]);
      end
    end
  endtask

  // ====================================================================
  // Main sequence and watchdog
  // ====================================================================
  initial begin
    void'($urandom(78));
    errors    = 0;
    checks    = 0;
    rst_n     = 1'b0;
    load_we   = 1'b0;
    load_sel  = 1'b0;
    load_addr = '0;
    load_data = '0;
    start     = 1'b0;
    row_len   = '0;
    for (int i = 0; i < NUM_FEAT_IN; i++) begin
      m_col[i] = '0;
      m_val[i] = '0;
      for (int j = 0; j < NUM_FEAT_OUT; j++) begin
        m_wgt[i][j] = '0;
      end
    end
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    test_reset();
    test_single();
    test_full();
    test_extremes();
    test_back_to_back();
    test_weight_view();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    #(WDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d cycles", WDOG_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

endmodule
